//--- build.f
+incdir+tests
src/frame_parser_pkg.sv
src/crc8_engine.sv
src/idle_timer.sv
src/frame_field_capture.sv
src/frame_sequencer.sv
src/frame_parser_top.sv
tests/tb_frame_parser.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the frame parser testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f build.f --top-module tb_frame_parser -o sim_tb; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1

//--- tests/tb_frame_tasks.svh
`ifndef TB_FRAME_TASKS_SVH
`define TB_FRAME_TASKS_SVH

// Bitwise reference CRC-8 with poly 0x07 and init 0x00 that takes message bits MSB first
function automatic logic [7:0] crc8_ref(input logic [7:0] bytes[$]);
    logic [7:0] crc;
    logic       fb;
    crc = 8'h00;
    foreach (bytes[i]) begin
        for (int b = 7; b >= 0; b--) begin
            fb  = crc[7] ^ bytes[i][b];
            crc = {crc[6:0], 1'b0} ^ (fb ? 8'h07 : 8'h00);
        end
    end
    return crc;
endfunction

// (len + 1) beats of 1, 2 or 4 bytes; reads and reserved size carry none
function automatic int payload_bytes(input logic [7:0] cmd);
    if (cmd[7] || cmd[5:4] == 2'b11) begin
        return 0;
    end
    return (int'(cmd[3:0]) + 1) << cmd[5:4];
endfunction

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
endtask

// Builds a frame behind a few junk bytes and loads it into the FIFO
task automatic send_frame(input logic [7:0] cmd, input logic [31:0] addr,
                          input bit bad_crc, input bit cut);
    logic [7:0] body[$];
    logic [7:0] junk;
    int         n_junk;
    n_junk = $urandom_range(0, 3);
    sent_data.delete();
    body.push_back(cmd);
    for (int k = 0; k < 4; k++) begin
        body.push_back(addr[8*k +: 8]);  // LSB first
    end
    if (!cut) begin
        for (int i = 0; i < payload_bytes(cmd); i++) begin
            sent_data.push_back(8'($urandom));
            body.push_back(sent_data[i]);
        end
    end
    @(negedge clk);
    repeat (n_junk) begin
        junk = 8'($urandom);
        fifo_q.push_back((junk == SOF_HOST_TO_DEVICE) ? 8'h00 : junk);
    end
    fifo_q.push_back(SOF_HOST_TO_DEVICE);
    foreach (body[i]) begin
        fifo_q.push_back(body[i]);
    end
    if (!cut) begin
        fifo_q.push_back(crc8_ref(body) ^ (bad_crc ? 8'h5A : 8'h00));
    end
endtask

task automatic wait_result(input int limit, output int cycles);
    cycles = 0;
    @(negedge clk);
    while (!frame_valid && !frame_error && cycles < limit) begin
        @(negedge clk);
        cycles++;
    end
    if (!frame_valid && !frame_error) begin
        errors++;
        $display("No result from the parser within %0d cycles at %0t", limit, $time);
    end
endtask

// One-cycle consumed pulse after which the result must drop
task automatic release_result();
    @(posedge clk);
    frame_consumed <= 1'b1;
    @(posedge clk);
    frame_consumed <= 1'b0;
    @(negedge clk);
    check_val("frame_valid after release", 32'(frame_valid), 32'd0);
    check_val("frame_error after release", 32'(frame_error), 32'd0);
    check_val("parser_busy after release", 32'(parser_busy), 32'd0);
endtask

// Outputs just after reset while the FIFO is still empty
task automatic check_reset_state();
    @(negedge clk);
    check_val("rx_fifo_rd_en after reset", 32'(rx_fifo_rd_en), 32'd0);
    check_val("frame_valid after reset", 32'(frame_valid), 32'd0);
    check_val("frame_error after reset", 32'(frame_error), 32'd0);
    check_val("parser_busy after reset", 32'(parser_busy), 32'd0);
    check_val("error_status after reset", 32'(error_status), 32'(STATUS_OK));
endtask

task automatic expect_frame(input logic [7:0] cmd, input logic [31:0] addr);
    int cycles;
    int n;
    n = payload_bytes(cmd);
    wait_result(5000, cycles);
    check_val("frame_valid", 32'(frame_valid), 32'd1);
    check_val("frame_error", 32'(frame_error), 32'd0);
    check_val("error_status", 32'(error_status), 32'(STATUS_OK));
    check_val("frame.cmd", 32'(frame.cmd), 32'(cmd));
    check_val("frame.addr", frame.addr, addr);
    check_val("frame.data_count", 32'(frame.data_count), n);
    for (int i = 0; i < n; i++) begin
        @(posedge clk);
        data_rd_index <= DATA_INDEX_W'(i);
        @(negedge clk);
        check_val($sformatf("data_rd_byte[%0d]", i), 32'(data_rd_byte), 32'(sent_data[i]));
    end
endtask

task automatic expect_error(input parser_status_e status, input int limit, output int cycles);
    wait_result(limit, cycles);
    check_val("frame_error", 32'(frame_error), 32'd1);
    check_val("frame_valid", 32'(frame_valid), 32'd0);
    check_val("error_status", 32'(error_status), 32'(status));
endtask

task automatic test_write(input size_e size, input logic [3:0] len);
    logic [7:0]  cmd;
    logic [31:0] addr;
    cmd  = {1'b0, 1'($urandom), size, len};
    addr = $urandom;
    send_frame(cmd, addr, 1'b0, 1'b0);
    expect_frame(cmd, addr);
    release_result();
endtask

task automatic test_read();
    logic [7:0]  cmd;
    logic [31:0] addr;
    cmd  = {1'b1, 1'($urandom), SIZE_32, 4'($urandom)};
    addr = $urandom;
    send_frame(cmd, addr, 1'b0, 1'b0);
    expect_frame(cmd, addr);  // No payload expected
    release_result();
endtask

task automatic test_crc_error();
    int cycles;
    send_frame({1'b0, 1'b1, SIZE_16, 4'($urandom)}, $urandom, 1'b1, 1'b0);
    expect_error(STATUS_CRC_ERR, 5000, cycles);
    release_result();
endtask

// Bad CRC byte as well so the command error has to win
task automatic test_reserved_size();
    int cycles;
    send_frame({1'b0, 1'b0, SIZE_RSVD, 4'($urandom)}, $urandom, 1'b1, 1'b0);
    expect_error(STATUS_CMD_INV, 5000, cycles);
    release_result();
endtask

task automatic test_timeout();
    int cycles;
    send_frame({1'b0, 1'b1, SIZE_8, 4'd3}, $urandom, 1'b0, 1'b1);
    // Up to 9 cycles go to reading the cut frame before the stall
    expect_error(STATUS_TIMEOUT, TIMEOUT_CLOCKS + 5 + 9, cycles);
    checks++;
    if (cycles < TIMEOUT_CLOCKS) begin
        errors++;
        $display("Timeout was reported after only %0d cycles", cycles);
    end
    release_result();
endtask

task automatic test_hold_release();
    logic [7:0]  cmd_b;
    logic [31:0] addr_a;
    logic [31:0] addr_b;
    int          fill;
    addr_a = $urandom;
    send_frame({1'b0, 1'b1, SIZE_8, 4'd7}, addr_a, 1'b0, 1'b0);
    expect_frame({1'b0, 1'b1, SIZE_8, 4'd7}, addr_a);
    cmd_b  = {1'b0, 1'b0, SIZE_16, 4'($urandom)};
    addr_b = $urandom;
    send_frame(cmd_b, addr_b, 1'b0, 1'b0);
    fill = fifo_q.size();
    repeat (20) @(negedge clk);
    check_val("FIFO fill while result held", fifo_q.size(), fill);
    check_val("parser_busy while result held", 32'(parser_busy), 32'd1);
    check_val("frame_valid while result held", 32'(frame_valid), 32'd1);
    release_result();
    expect_frame(cmd_b, addr_b);
    release_result();
endtask

`endif

//--- tests/tb_frame_parser.sv
`timescale 1ns/1ps
`default_nettype none

module tb_frame_parser import frame_parser_pkg::*; ();

    // Timeout test plus a margin of 5000 cycles for every other test
    localparam int WATCHDOG_CYCLES = 300_000;

    logic                    clk;
    logic                    rst;
    logic [7:0]              rx_fifo_data;
    logic                    rx_fifo_empty;
    logic                    frame_consumed;
    logic [DATA_INDEX_W-1:0] data_rd_index;
    logic                    rx_fifo_rd_en;
    frame_info_t             frame;
    logic [7:0]              data_rd_byte;
    logic                    frame_valid;
    logic                    frame_error;
    parser_status_e          error_status;
    logic                    parser_busy;

    logic [7:0] fifo_q[$];     // Bytes waiting in the receive FIFO
    logic [7:0] sent_data[$];  // Payload of the last frame built
    int         checks = 0;
    int         errors = 0;

    frame_parser_top uut (
        .clk            (clk),
        .rst            (rst),
        .rx_fifo_data   (rx_fifo_data),
        .rx_fifo_empty  (rx_fifo_empty),
        .frame_consumed (frame_consumed),
        .data_rd_index  (data_rd_index),
        .rx_fifo_rd_en  (rx_fifo_rd_en),
        .frame          (frame),
        .data_rd_byte   (data_rd_byte),
        .frame_valid    (frame_valid),
        .frame_error    (frame_error),
        .error_status   (error_status),
        .parser_busy    (parser_busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // FIFO model presents the head byte while the queue is not empty
    always @(posedge clk) begin
        if (rx_fifo_rd_en && rx_fifo_empty) begin
            errors++;
            $display("FIFO read strobe was high while the FIFO was empty at %0t", $time);
        end
        if (rx_fifo_rd_en && fifo_q.size() > 0) begin
            void'(fifo_q.pop_front());
        end
        rx_fifo_empty <= (fifo_q.size() == 0);
        rx_fifo_data  <= (fifo_q.size() > 0) ? fifo_q[0] : 8'h00;
    end

    `include "tb_frame_tasks.svh"

    initial begin
        void'($urandom(93));
        rst            = 1'b1;
        rx_fifo_data   = 8'h00;
        rx_fifo_empty  = 1'b1;
        frame_consumed = 1'b0;
        data_rd_index  = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        check_reset_state();
        test_write(SIZE_8, 4'($urandom));
        test_write(SIZE_16, 4'($urandom));
        test_write(SIZE_32, 4'($urandom));
        test_write(SIZE_32, 4'hF);  // Full 64-byte buffer
        test_read();
        test_crc_error();
        test_reserved_size();
        test_timeout();
        test_hold_release();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, test sequence did not finish",
                 WATCHDOG_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/frame_parser_top.sv
`timescale 1ns/1ps
`default_nettype none

module frame_parser_top import frame_parser_pkg::*; (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic [7:0]              rx_fifo_data,
    input  wire logic                    rx_fifo_empty,
    input  wire logic                    frame_consumed,
    input  wire logic [DATA_INDEX_W-1:0] data_rd_index,
    output logic                         rx_fifo_rd_en,
    output frame_info_t                  frame,
    output logic [7:0]                   data_rd_byte,
    output logic                         frame_valid,
    output logic                         frame_error,
    output parser_status_e               error_status,
    output logic                         parser_busy
);

    parser_state_e state;
    capture_ctrl_t capture;
    cmd_fields_t   cmd_fields;
    logic          data_last;
    logic          crc_clear;
    logic          crc_take;
    logic [7:0]    crc_value;
    logic          frame_active;
    logic          timeout;

    frame_sequencer u_sequencer (
        .clk            (clk),
        .rst            (rst),
        .rx_fifo_data   (rx_fifo_data),
        .rx_fifo_empty  (rx_fifo_empty),
        .frame_consumed (frame_consumed),
        .cmd_fields     (cmd_fields),
        .data_last      (data_last),
        .crc_value      (crc_value),
        .timeout        (timeout),
        .rx_fifo_rd_en  (rx_fifo_rd_en),
        .state          (state),
        .capture        (capture),
        .crc_clear      (crc_clear),
        .crc_take       (crc_take),
        .frame_active   (frame_active),
        .frame_valid    (frame_valid),
        .frame_error    (frame_error),
        .error_status   (error_status),
        .parser_busy    (parser_busy)
    );

    frame_field_capture u_capture (
        .clk           (clk),
        .rst           (rst),
        .state         (state),
        .capture       (capture),
        .rx_fifo_data  (rx_fifo_data),
        .data_rd_index (data_rd_index),
        .cmd_fields    (cmd_fields),
        .frame         (frame),
        .data_last     (data_last),
        .data_rd_byte  (data_rd_byte)
    );

    // CRC covers command, address and data bytes only
    crc8_engine u_crc (
        .clk       (clk),
        .rst       (rst),
        .crc_clear (crc_clear),
        .crc_take  (crc_take),
        .data_in   (rx_fifo_data),
        .crc_value (crc_value)
    );

    idle_timer u_idle_timer (
        .clk           (clk),
        .rst           (rst),
        .frame_active  (frame_active),
        .rx_fifo_empty (rx_fifo_empty),
        .timeout       (timeout)
    );

endmodule

`default_nettype wire

//--- src/frame_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer import frame_parser_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic [7:0]  rx_fifo_data,
    input  wire logic        rx_fifo_empty,
    input  wire logic        frame_consumed,
    input  wire cmd_fields_t cmd_fields,
    input  wire logic        data_last,
    input  wire logic [7:0]  crc_value,
    input  wire logic        timeout,
    output logic             rx_fifo_rd_en,
    output parser_state_e    state,
    output capture_ctrl_t    capture,
    output logic             crc_clear,
    output logic             crc_take,
    output logic             frame_active,
    output logic             frame_valid,
    output logic             frame_error,
    output parser_status_e   error_status,
    output logic             parser_busy
);

    parser_state_e  state_next;
    parser_status_e status_next;
    logic           byte_in;   // Frame byte available this cycle
    logic           has_data;  // Write with a usable size carries a payload

    // Timer runs from the command byte up to the CRC byte
    assign frame_active = (state == ST_CMD)   || (state == ST_ADDR0) ||
                          (state == ST_ADDR1) || (state == ST_ADDR2) ||
                          (state == ST_ADDR3) || (state == ST_DATA)  ||
                          (state == ST_CRC);

    assign byte_in  = frame_active && !rx_fifo_empty;
    assign has_data = !cmd_fields.rw && (cmd_fields.size != SIZE_RSVD);

    always_comb begin
        state_next        = state;
        status_next       = error_status;
        rx_fifo_rd_en     = 1'b0;
        crc_clear         = 1'b0;
        crc_take          = 1'b0;
        capture.frame_start = 1'b0;
        capture.field     = CAP_NONE;

        // Common handling of the in-frame states
        if (frame_active) begin
            if (!rx_fifo_empty) begin
                rx_fifo_rd_en = 1'b1;
                crc_take      = (state != ST_CRC);  // CRC byte itself is not folded
            end else if (timeout) begin
                state_next  = ST_ERROR;
                status_next = STATUS_TIMEOUT;
            end
        end

        case (state)
            ST_IDLE: begin
                crc_clear = 1'b1;
                if (!rx_fifo_empty) begin
                    rx_fifo_rd_en = 1'b1;  // Anything but SOF is dropped
                    if (rx_fifo_data == SOF_HOST_TO_DEVICE) begin
                        capture.frame_start = 1'b1;
                        state_next          = ST_CMD;
                    end
                end
            end
            ST_CMD: begin
                if (byte_in) begin
                    capture.field = CAP_CMD;
                    state_next    = ST_ADDR0;
                end
            end
            ST_ADDR0, ST_ADDR1, ST_ADDR2: begin
                if (byte_in) begin
                    capture.field = CAP_ADDR;
                    state_next    = parser_state_e'(state + 4'd1);
                end
            end
            ST_ADDR3: begin
                if (byte_in) begin
                    capture.field = CAP_ADDR;
                    state_next    = has_data ? ST_DATA : ST_CRC;
                end
            end
            ST_DATA: begin
                if (byte_in) begin
                    capture.field = CAP_DATA;
                    if (data_last) begin
                        state_next = ST_CRC;
                    end
                end
            end
            ST_CRC: begin
                if (byte_in) begin
                    state_next = ST_VALIDATE;
                    // Reserved size wins over a CRC mismatch
                    if (cmd_fields.size == SIZE_RSVD) begin
                        status_next = STATUS_CMD_INV;
                    end else if (rx_fifo_data != crc_value) begin
                        status_next = STATUS_CRC_ERR;
                    end else begin
                        status_next = STATUS_OK;
                    end
                end
            end
            ST_VALIDATE, ST_ERROR: begin
                // Result is held, FIFO is left alone
                if (frame_consumed) begin
                    state_next  = ST_IDLE;
                    status_next = STATUS_OK;
                end
            end
            default: begin
                state_next  = ST_IDLE;
                status_next = STATUS_OK;
            end
        endcase

        capture.byte_take = rx_fifo_rd_en;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= ST_IDLE;
            error_status <= STATUS_OK;
        end else begin
            state        <= state_next;
            error_status <= status_next;
        end
    end

    assign frame_valid = (state == ST_VALIDATE) && (error_status == STATUS_OK);
    assign frame_error = (state == ST_ERROR) ||
                         ((state == ST_VALIDATE) && (error_status != STATUS_OK));
    assign parser_busy = (state != ST_IDLE);

endmodule

`default_nettype wire

//--- src/frame_field_capture.sv
`timescale 1ns/1ps
`default_nettype none

module frame_field_capture import frame_parser_pkg::*; (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire parser_state_e           state,
    input  wire capture_ctrl_t           capture,
    input  wire logic [7:0]              rx_fifo_data,
    input  wire logic [DATA_INDEX_W-1:0] data_rd_index,
    output cmd_fields_t                  cmd_fields,
    output frame_info_t                  frame,
    output logic                         data_last,
    output logic [7:0]                   data_rd_byte
);

    cmd_fields_t             cmd_q;
    logic [31:0]             addr_q;
    logic [DATA_COUNT_W-1:0] data_count_q;
    logic [7:0]              data_buf [MAX_DATA_BYTES];
    logic [4:0]              beats;           // len + 1, up to 16
    logic [DATA_COUNT_W-1:0] expected_bytes;
    logic                    take_cmd;
    logic                    take_addr;
    logic                    take_data;

    assign take_cmd  = capture.byte_take && (capture.field == CAP_CMD);
    assign take_addr = capture.byte_take && (capture.field == CAP_ADDR);
    assign take_data = capture.byte_take && (capture.field == CAP_DATA);

    // Command register and data count
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_q        <= '0;
            data_count_q <= '0;
        end else begin
            if (capture.frame_start) begin
                data_count_q <= '0;
            end else if (take_data) begin
                data_count_q <= data_count_q + DATA_COUNT_W'(1);
            end
            if (take_cmd) begin
                cmd_q <= cmd_fields_t'(rx_fifo_data);
            end
        end
    end

    // Address arrives least significant byte first
    always_ff @(posedge clk) begin
        if (take_addr) begin
            case (state)
                ST_ADDR0: addr_q[7:0]   <= rx_fifo_data;
                ST_ADDR1: addr_q[15:8]  <= rx_fifo_data;
                ST_ADDR2: addr_q[23:16] <= rx_fifo_data;
                ST_ADDR3: addr_q[31:24] <= rx_fifo_data;
                default:  addr_q        <= addr_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_data) begin
            data_buf[data_count_q[DATA_INDEX_W-1:0]] <= rx_fifo_data;
        end
    end

    assign beats = {1'b0, cmd_q.len} + 5'd1;

    always_comb begin
        case (cmd_q.size)
            SIZE_8:  expected_bytes = {2'b00, beats};
            SIZE_16: expected_bytes = {1'b0, beats, 1'b0};
            SIZE_32: expected_bytes = {beats, 2'b00};
            default: expected_bytes = '0;  // Reserved, no payload
        endcase
    end

    // Next data byte completes the payload
    assign data_last = (data_count_q + DATA_COUNT_W'(1)) == expected_bytes;

    assign cmd_fields      = cmd_q;
    assign frame.cmd        = cmd_q;
    assign frame.addr       = addr_q;
    assign frame.data_count = data_count_q;
    assign data_rd_byte     = data_buf[data_rd_index];

endmodule

`default_nettype wire

//--- src/idle_timer.sv
`timescale 1ns/1ps
`default_nettype none

module idle_timer import frame_parser_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic frame_active,
    input  wire logic rx_fifo_empty,
    output logic      timeout
);

    logic [TIMEOUT_W-1:0] idle_count;
    logic                 idle;

    // Only an empty FIFO inside a frame counts as idle
    assign idle = frame_active && rx_fifo_empty;

    always_ff @(posedge clk) begin
        if (rst || !idle) begin
            idle_count <= '0;
            timeout    <= 1'b0;
        end else if (idle_count == TIMEOUT_W'(TIMEOUT_CLOCKS)) begin
            timeout <= 1'b1;  // Set one cycle after the limit is reached
        end else begin
            idle_count <= idle_count + TIMEOUT_W'(1);
        end
    end

endmodule

`default_nettype wire

//--- src/crc8_engine.sv
`timescale 1ns/1ps
`default_nettype none

module crc8_engine import frame_parser_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       crc_clear,
    input  wire logic       crc_take,
    input  wire logic [7:0] data_in,
    output logic [7:0]      crc_value
);

    logic [7:0] crc_next;

    // One byte folded MSB first, all eight shifts in one cycle
    always_comb begin
        crc_next = crc_value ^ data_in;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[7]) begin
                crc_next = {crc_next[6:0], 1'b0} ^ CRC8_POLY;
            end else begin
                crc_next = {crc_next[6:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || crc_clear) begin
            crc_value <= 8'h00;  // Initial value
        end else if (crc_take) begin
            crc_value <= crc_next;
        end
    end

endmodule

`default_nettype wire

//--- src/frame_parser_pkg.sv
`default_nettype none

package frame_parser_pkg;

    // Frame protocol
    localparam logic [7:0] SOF_HOST_TO_DEVICE = 8'hA5;
    localparam logic [7:0] CRC8_POLY          = 8'h07;  // x^8 + x^2 + x + 1

    // Clock and line rate
    localparam int CLK_FREQ_HZ        = 125_000_000;
    localparam int BAUD_RATE          = 115_200;
    localparam int TIMEOUT_BYTE_TIMES = 10;

    // 10 bits per byte on the wire
    localparam int BYTE_TIME_CLOCKS = CLK_FREQ_HZ / (BAUD_RATE / 10);
    localparam int TIMEOUT_CLOCKS   = BYTE_TIME_CLOCKS * TIMEOUT_BYTE_TIMES;
    localparam int TIMEOUT_W        = $clog2(TIMEOUT_CLOCKS + 1);

    // Data buffer
    localparam int MAX_DATA_BYTES = 64;
    localparam int DATA_COUNT_W   = 7;  // Counts 0 to 64
    localparam int DATA_INDEX_W   = 6;

    typedef enum logic [1:0] {
        SIZE_8    = 2'b00,
        SIZE_16   = 2'b01,
        SIZE_32   = 2'b10,
        SIZE_RSVD = 2'b11
    } size_e;

    typedef struct packed {
        logic       rw;    // 1 means read
        logic       inc;   // Address increment
        size_e      size;
        logic [3:0] len;   // Beats minus one
    } cmd_fields_t;

    typedef enum logic [7:0] {
        STATUS_OK      = 8'h00,
        STATUS_CRC_ERR = 8'h01,
        STATUS_CMD_INV = 8'h02,
        STATUS_TIMEOUT = 8'h04
    } parser_status_e;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_CMD,
        ST_ADDR0,
        ST_ADDR1,
        ST_ADDR2,
        ST_ADDR3,
        ST_DATA,
        ST_CRC,
        ST_VALIDATE,
        ST_ERROR
    } parser_state_e;

    // Destination of an accepted byte
    typedef enum logic [1:0] {
        CAP_NONE,
        CAP_CMD,
        CAP_ADDR,
        CAP_DATA
    } capture_sel_e;

    typedef struct packed {
        logic         byte_take;    // Byte accepted this cycle
        logic         frame_start;  // SOF accepted
        capture_sel_e field;
    } capture_ctrl_t;

    typedef struct packed {
        cmd_fields_t             cmd;
        logic [31:0]             addr;
        logic [DATA_COUNT_W-1:0] data_count;
    } frame_info_t;

endpackage

`default_nettype wire
